// File: hw/acc_core.sv
`timescale 1ns/10ps
`include "lockstep_defs.svh"

module acc_core (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  logic                     cmd_valid_i,
  input  lockstep_pkg::cmd_word_u  cmd_word_i,

  output logic [`LS_DATA_W-1:0]    acc_o,
  output logic                     carry_o
);

  logic [`LS_DATA_W-1:0] acc_q;
  logic [`LS_DATA_W-1:0] acc_d;
  logic                  carry_q;
  logic                  carry_d;
  logic [`LS_DATA_W-1:0] operand_sh;
  logic [`LS_DATA_W:0]   sum;

  ////////////////////////////////////////
  // Operand path
  ////////////////////////////////////////

  // ALU view, zero-extended operand shifted left
  assign operand_sh = `LS_DATA_W'(cmd_word_i.alu.operand) << cmd_word_i.alu.shamt;

  // Extra top bit holds the carry out
  assign sum = {1'b0, acc_q} + {1'b0, operand_sh};

  ////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////

  always_comb begin
    acc_d   = acc_q;
    carry_d = carry_q;
    if (cmd_valid_i) begin
      case (cmd_word_i.load.opcode)
        `LS_OP_LOAD: begin
          acc_d   = `LS_DATA_W'(cmd_word_i.load.imm);
          carry_d = 1'b0;
        end
        `LS_OP_ADD: begin
          acc_d   = sum[`LS_DATA_W-1:0];
          carry_d = sum[`LS_DATA_W];
        end
        `LS_OP_XOR: begin
          acc_d = acc_q ^ operand_sh;
        end
        default: begin
          // NOP and unknown opcodes hold state
          acc_d = acc_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q   <= '0;
      carry_q <= 1'b0;
    end else begin
      acc_q   <= acc_d;
      carry_q <= carry_d;
    end
  end

  assign acc_o   = acc_q;
  assign carry_o = carry_q;

endmodule

// File: hw/lockstep_apb_regs.sv
`timescale 1ns/10ps
`include "lockstep_defs.svh"

module lockstep_apb_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // APB slave
  input  logic [`LS_APB_ADDR_W-1:0]  paddr_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [`LS_DATA_W-1:0]      pwdata_i,
  output logic [`LS_DATA_W-1:0]      prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,

  // Main lane state and alert for readback
  input  logic [`LS_DATA_W-1:0]      main_acc_i,
  input  logic                       main_carry_i,
  input  logic                       alert_i,

  // Command pulse towards the feeder
  output logic                       cmd_valid_o,
  output lockstep_pkg::cmd_word_u    cmd_word_o
);

  logic                    access;
  logic                    is_cmd;
  logic                    is_acc;
  logic                    is_status;
  logic                    mapped;
  logic                    bad_dir;
  logic                    cmd_issue;
  logic                    cmd_valid_q;
  lockstep_pkg::cmd_word_u cmd_word_q;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign access    = psel_i & penable_i;
  assign is_cmd    = (paddr_i == `LS_ADDR_CMD);
  assign is_acc    = (paddr_i == `LS_ADDR_ACC);
  assign is_status = (paddr_i == `LS_ADDR_STATUS);
  assign mapped    = is_cmd | is_acc | is_status;

  // CMD is write only, ACC and STATUS are read only
  assign bad_dir   = pwrite_i ? (is_acc | is_status) : is_cmd;

  assign pready_o  = 1'b1;
  assign pslverr_o = access & (~mapped | bad_dir);

  assign cmd_issue = access & pwrite_i & is_cmd;

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  always_comb begin
    prdata_o = '0;
    if (is_acc) begin
      prdata_o = main_acc_i;
    end else if (is_status) begin
      prdata_o = {{(`LS_DATA_W-2){1'b0}}, main_carry_i, alert_i};
    end
  end

  ////////////////////////////////////////
  // Command pulse
  ////////////////////////////////////////

  // One cycle pulse in the cycle after the access phase
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_valid_q <= 1'b0;
    end else begin
      cmd_valid_q <= cmd_issue;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_issue) begin
      cmd_word_q <= pwdata_i;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_word_o  = cmd_word_q;

endmodule

// File: hw/lockstep_compare.sv
`timescale 1ns/10ps
`include "lockstep_defs.svh"

module lockstep_compare (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic [`LS_DATA_W-1:0]  main_acc_i,
  input  logic                   main_carry_i,
  input  logic [`LS_DATA_W-1:0]  shadow_acc_i,
  input  logic                   shadow_carry_i,

  input  logic                   cmp_en_i,
  output logic                   alert_o
);

  // One extra stage matches the shadow output register
  localparam int unsigned out_dly = `LS_OFFSET + 1;

  logic [`LS_DATA_W:0] main_dly_q [out_dly];
  logic [`LS_DATA_W:0] shadow_q;
  logic                mismatch;
  logic                alert_q;

  ////////////////////////////////////////
  // Output alignment
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    main_dly_q[0] <= {main_carry_i, main_acc_i};
    for (int i = 1; i < out_dly; i++) begin
      main_dly_q[i] <= main_dly_q[i-1];
    end
  end

  // Shadow outputs registered once
  always_ff @(posedge clk_i) begin
    shadow_q <= {shadow_carry_i, shadow_acc_i};
  end

  ////////////////////////////////////////
  // Mismatch detection
  ////////////////////////////////////////

  assign mismatch = cmp_en_i & (shadow_q != main_dly_q[out_dly-1]);

  // Sticky until the next reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= alert_q | mismatch;
    end
  end

  assign alert_o = alert_q;

endmodule

// File: hw/lockstep_feed.sv
`timescale 1ns/10ps
`include "lockstep_defs.svh"

module lockstep_feed (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,

  input  logic                                          cmd_valid_i,
  input  lockstep_pkg::cmd_word_u                       cmd_word_i,

  output logic [`LS_NUM_LANES-1:0]                      lane_valid_o,
  output lockstep_pkg::cmd_word_u [`LS_NUM_LANES-1:0]   lane_word_o,

  output logic                                          shadow_rst_no,
  output logic                                          cmp_en_o
);

  localparam lockstep_pkg::cmd_word_u nop_cmd = {`LS_OP_NOP, {(`LS_DATA_W-4){1'b0}}};

  logic [`LS_OFFSET_W-1:0]                 rst_cnt_q;
  logic [`LS_OFFSET_W-1:0]                 rst_cnt_d;
  logic                                    rst_set_d;
  logic                                    rst_set_q;
  logic                                    cmp_en_q;
  logic [`LS_OFFSET-1:0]                   dly_valid_q;
  lockstep_pkg::cmd_word_u [`LS_OFFSET-1:0] dly_word_q;

  ////////////////////////////////////////
  // Shadow reset release
  ////////////////////////////////////////

  // Counter stops once the offset is reached
  assign rst_set_d = (rst_cnt_q == `LS_OFFSET_W'(`LS_OFFSET - 1));
  assign rst_cnt_d = rst_set_d ? rst_cnt_q : rst_cnt_q + `LS_OFFSET_W'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_cnt_q <= '0;
      rst_set_q <= 1'b0;
      cmp_en_q  <= 1'b0;
    end else begin
      rst_cnt_q <= rst_cnt_d;
      rst_set_q <= rst_set_d;
      // Compare one cycle after the shadow leaves reset
      cmp_en_q  <= rst_set_q;
    end
  end

  assign shadow_rst_no = rst_set_q;
  assign cmp_en_o      = cmp_en_q;

  ////////////////////////////////////////
  // Command delay line
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dly_valid_q <= '0;
      dly_word_q  <= {`LS_OFFSET{nop_cmd}};
    end else begin
      dly_valid_q[0] <= cmd_valid_i;
      dly_word_q[0]  <= cmd_word_i;
      for (int i = 1; i < `LS_OFFSET; i++) begin
        dly_valid_q[i] <= dly_valid_q[i-1];
        dly_word_q[i]  <= dly_word_q[i-1];
      end
    end
  end

  // Lane 0 runs straight off the pulse, lane 1 trails it
  assign lane_valid_o[0] = cmd_valid_i;
  assign lane_word_o[0]  = cmd_word_i;
  assign lane_valid_o[1] = dly_valid_q[`LS_OFFSET-1];
  assign lane_word_o[1]  = dly_word_q[`LS_OFFSET-1];

endmodule

// File: hw/lockstep_pkg.sv
`include "lockstep_defs.svh"

package lockstep_pkg;

  ////////////////////////////////////////
  // Command word
  ////////////////////////////////////////

  // Opcode always sits in the top nibble
  // LOAD uses the long immediate, ALU ops use shift plus operand
  typedef union packed {
    struct packed {
      logic [3:0]              opcode;
      logic [`LS_DATA_W-5:0]   imm;
    } load;
    struct packed {
      logic [3:0]              opcode;
      logic [3:0]              shamt;
      logic [`LS_DATA_W-9:0]   operand;
    } alu;
  } cmd_word_u;

endpackage

// File: hw/lockstep_top.sv
`timescale 1ns/10ps
`include "lockstep_defs.svh"

module lockstep_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic [`LS_APB_ADDR_W-1:0]  paddr_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [`LS_DATA_W-1:0]      pwdata_i,
  output logic [`LS_DATA_W-1:0]      prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,

  output logic                       alert_major_o
);

  logic                                         cmd_valid;
  lockstep_pkg::cmd_word_u                      cmd_word;
  logic [`LS_NUM_LANES-1:0]                     lane_valid;
  lockstep_pkg::cmd_word_u [`LS_NUM_LANES-1:0]  lane_word;
  logic                                         shadow_rst_n;
  logic                                         cmp_en;
  logic [`LS_DATA_W-1:0]                        lane_acc [`LS_NUM_LANES];
  logic [`LS_NUM_LANES-1:0]                     lane_carry;

  lockstep_apb_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .main_acc_i   (lane_acc[0]),
    .main_carry_i (lane_carry[0]),
    .alert_i      (alert_major_o),
    .cmd_valid_o  (cmd_valid),
    .cmd_word_o   (cmd_word)
  );

  lockstep_feed u_feed (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_valid_i   (cmd_valid),
    .cmd_word_i    (cmd_word),
    .lane_valid_o  (lane_valid),
    .lane_word_o   (lane_word),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  ////////////////////////////////////////
  // Main and shadow lanes
  ////////////////////////////////////////

  for (genvar i = 0; i < `LS_NUM_LANES; i++) begin : g_lane
    logic lane_rst_n;

    // Shadow lane leaves reset late
    assign lane_rst_n = (i == 0) ? rst_ni : (rst_ni & shadow_rst_n);

    acc_core u_core (
      .clk_i       (clk_i),
      .rst_ni      (lane_rst_n),
      .cmd_valid_i (lane_valid[i]),
      .cmd_word_i  (lane_word[i]),
      .acc_o       (lane_acc[i]),
      .carry_o     (lane_carry[i])
    );
  end

  lockstep_compare u_cmp (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .main_acc_i     (lane_acc[0]),
    .main_carry_i   (lane_carry[0]),
    .shadow_acc_i   (lane_acc[1]),
    .shadow_carry_i (lane_carry[1]),
    .cmp_en_i       (cmp_en),
    .alert_o        (alert_major_o)
  );

endmodule

// File: include/lockstep_defs.svh
`ifndef LOCKSTEP_DEFS_SVH
`define LOCKSTEP_DEFS_SVH

// Datapath and lockstep geometry
`define LS_DATA_W     32
`define LS_OFFSET     2
`define LS_OFFSET_W   1
`define LS_NUM_LANES  2

// Command opcodes, anything else is treated as NOP
`define LS_OP_NOP     4'h0
`define LS_OP_LOAD    4'h1
`define LS_OP_ADD     4'h2
`define LS_OP_XOR     4'h3

// APB register byte offsets
`define LS_APB_ADDR_W   4
`define LS_ADDR_CMD     4'h0
`define LS_ADDR_ACC     4'h4
`define LS_ADDR_STATUS  4'h8

`endif

// File: lockstep_acc.f
+incdir+include
hw/lockstep_pkg.sv
hw/lockstep_apb_regs.sv
hw/lockstep_feed.sv
hw/acc_core.sv
hw/lockstep_compare.sv
hw/lockstep_top.sv
test/tb_lockstep.sv

// File: run.sh
#!/bin/sh
# Build and run the lockstep accumulator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_lockstep -f lockstep_acc.f -o vtb_lockstep || exit 1
out=$(./obj_dir/vtb_lockstep 2>&1)
echo "$out"
echo "$out" | grep -q "All tests passed!" && exit 0 || exit 1

// File: test/tb_lockstep.sv
`timescale 1ns/10ps
`include "lockstep_defs.svh"

module tb_lockstep;

  localparam int clk_period = 40;
  localparam int num_cmds   = 400;
  localparam int num_tests  = num_cmds + 40;
  localparam int timeout_ns = num_tests * 10 * clk_period + 100 * clk_period;

  logic                      clk;
  logic                      rst_n;
  logic [`LS_APB_ADDR_W-1:0] paddr;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [`LS_DATA_W-1:0]     pwdata;
  logic [`LS_DATA_W-1:0]     prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      alert_major;

  // Alert pin as seen together with the last read data
  logic                      alert_seen;

  // Reference model state
  logic [`LS_DATA_W-1:0]     model_acc;
  logic                      model_carry;

  lockstep_top dut_i (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .paddr_i       (paddr),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .pwdata_i      (pwdata),
    .prdata_o      (prdata),
    .pready_o      (pready),
    .pslverr_o     (pslverr),
    .alert_major_o (alert_major)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(timeout_ns);
    $display("Timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_acc(input logic [`LS_DATA_W-1:0] got,
                           input logic [`LS_DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s: acc got %08h, expected %08h", what, got, exp));
    end
  endtask

  // STATUS word and the alert pin together
  task automatic check_status(input logic [`LS_DATA_W-1:0] status_word, input logic alert_pin,
                              input logic exp_alert, input logic exp_carry, input string what);
    if (status_word !== {{(`LS_DATA_W-2){1'b0}}, exp_carry, exp_alert}) begin
      report_fail($sformatf("%s: status got %08h, expected alert %0b carry %0b",
                            what, status_word, exp_alert, exp_carry));
    end
    if (alert_pin !== exp_alert) begin
      report_fail($sformatf("%s: alert_major_o got %0b, expected %0b", what, alert_pin,
                            exp_alert));
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s: pslverr_o got %0b, expected %0b", what, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // APB host
  ////////////////////////////////////////

  task automatic apb_access(input logic wr, input logic [`LS_APB_ADDR_W-1:0] addr,
                            input logic [`LS_DATA_W-1:0] wdata,
                            output logic [`LS_DATA_W-1:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    // Sample in the middle of the access phase
    @(negedge clk);
    rdata      = prdata;
    err        = pslverr;
    alert_seen = alert_major;
    if (pready !== 1'b1) begin
      report_fail("pready_o low during access phase");
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [`LS_APB_ADDR_W-1:0] addr,
                           input logic [`LS_DATA_W-1:0] wdata, input logic exp_err);
    logic [`LS_DATA_W-1:0] unused_rdata;
    logic                  err;
    apb_access(1'b1, addr, wdata, unused_rdata, err);
    check_err(err, exp_err, $sformatf("write to %0h", addr));
  endtask

  task automatic apb_read(input logic [`LS_APB_ADDR_W-1:0] addr,
                          output logic [`LS_DATA_W-1:0] rdata, input logic exp_err);
    logic err;
    apb_access(1'b0, addr, '0, rdata, err);
    check_err(err, exp_err, $sformatf("read of %0h", addr));
  endtask

  ////////////////////////////////////////
  // Reference model and stimulus
  ////////////////////////////////////////

  task automatic model_apply(input lockstep_pkg::cmd_word_u cmd);
    logic [63:0] wide;
    logic [63:0] total;
    wide  = 64'(cmd.alu.operand) << cmd.alu.shamt;
    total = 64'(model_acc) + 64'(wide[`LS_DATA_W-1:0]);
    case (cmd.load.opcode)
      `LS_OP_LOAD: begin
        model_acc   = {4'h0, cmd.load.imm};
        model_carry = 1'b0;
      end
      `LS_OP_ADD: begin
        model_acc   = total[`LS_DATA_W-1:0];
        model_carry = total[`LS_DATA_W];
      end
      `LS_OP_XOR: model_acc = model_acc ^ wide[`LS_DATA_W-1:0];
      default: ;
    endcase
  endtask

  // Half the picks land on the four real opcodes
  function automatic lockstep_pkg::cmd_word_u random_cmd();
    lockstep_pkg::cmd_word_u cmd;
    int unsigned             pick;
    pick = $urandom_range(0, 7);
    cmd  = $urandom;
    if (pick < 4) begin
      cmd.load.opcode = 4'(pick);
    end else begin
      cmd.load.opcode = 4'($urandom_range(4, 15));
    end
    return cmd;
  endfunction

  task automatic run_cmd(input lockstep_pkg::cmd_word_u cmd, input logic exp_alert);
    logic [`LS_DATA_W-1:0] rdata;
    model_apply(cmd);
    apb_write(`LS_ADDR_CMD, cmd, 1'b0);
    apb_read(`LS_ADDR_ACC, rdata, 1'b0);
    check_acc(rdata, model_acc, $sformatf("after cmd %08h", cmd));
    apb_read(`LS_ADDR_STATUS, rdata, 1'b0);
    check_status(rdata, alert_seen, exp_alert, model_carry, $sformatf("after cmd %08h", cmd));
  endtask

  initial begin
    logic [`LS_DATA_W-1:0] rdata;
    logic [`LS_DATA_W-1:0] flip_val;
    void'($urandom(32'h88f9));
    rst_n       = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    model_acc   = '0;
    model_carry = 1'b0;
    alert_seen  = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // Let the shadow leave reset and compare come on
    repeat (5) @(posedge clk);

    apb_read(`LS_ADDR_ACC, rdata, 1'b0);
    check_acc(rdata, '0, "ACC after reset");
    apb_read(`LS_ADDR_STATUS, rdata, 1'b0);
    check_status(rdata, alert_seen, 1'b0, 1'b0, "STATUS after reset");

    for (int i = 0; i < num_cmds; i++) begin
      run_cmd(random_cmd(), 1'b0);
    end
    repeat (`LS_OFFSET + 3) @(posedge clk);
    apb_read(`LS_ADDR_STATUS, rdata, 1'b0);
    check_status(rdata, alert_seen, 1'b0, model_carry, "after random commands");

    // Illegal accesses must not touch the accumulator
    apb_write(`LS_ADDR_ACC, $urandom, 1'b1);
    apb_write(`LS_ADDR_STATUS, $urandom, 1'b1);
    apb_read(`LS_ADDR_CMD, rdata, 1'b1);
    apb_write(4'hc, $urandom, 1'b1);
    apb_read(4'hc, rdata, 1'b1);
    apb_read(`LS_ADDR_ACC, rdata, 1'b0);
    check_acc(rdata, model_acc, "after slave errors");

    ////////////////////////////////////////
    // Fault injection on the shadow lane
    ////////////////////////////////////////

    @(negedge clk);
    flip_val = ~dut_i.g_lane[1].u_core.acc_o;
    force dut_i.g_lane[1].u_core.acc_o = flip_val;
    @(negedge clk);
    release dut_i.g_lane[1].u_core.acc_o;
    for (int n = 0; n < `LS_OFFSET + 2; n++) begin
      @(negedge clk);
      if (alert_major) break;
    end
    if (alert_major !== 1'b1) begin
      report_fail("alert_major_o not raised after shadow fault");
    end
    apb_read(`LS_ADDR_STATUS, rdata, 1'b0);
    check_status(rdata, alert_seen, 1'b1, model_carry, "after shadow fault");
    for (int i = 0; i < 5; i++) begin
      run_cmd(random_cmd(), 1'b1);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule
